//--- src/album_pkg.sv
`default_nettype none

package album_pkg;

    // -------------------------------------------------------------------------
    // memory and pixel widths
    // -------------------------------------------------------------------------
    localparam int IM_AW        = 20;   // image memory address
    localparam int PIX_W        = 24;   // rgb pixel
    localparam int CR_AW        = 9;    // char rom address
    localparam int GLYPH_W      = 13;   // glyph width, also rom word width
    localparam int GLYPH_H      = 24;   // rows per glyph

    localparam int PHOTO_SIDE   = 256;
    localparam int PHOTO_PIXELS = PHOTO_SIDE * PHOTO_SIDE;

    // overlay window and header layout
    localparam logic [IM_AW-1:0] CR_OFFSET = 20'he898;   // row 232, col 152
    localparam int N_GLYPH_COLS  = 8;    // h h : m m : s s
    localparam int COLON_GLYPH   = 10;
    localparam int N_PHOTO_SLOTS = 4;
    localparam int HDR_WORDS     = 7;    // time, fb addr, photo num, 4 slots
    localparam int SLOT_W        = $clog2(N_PHOTO_SLOTS);

    // -------------------------------------------------------------------------
    // sequencing
    // -------------------------------------------------------------------------
    localparam int FRAME_CYCLES = 1_000_000;
    localparam int FRAME_W      = $clog2(FRAME_CYCLES);
    localparam int SETUP_CYCLES = HDR_WORDS + 1;       // last word lands one late
    localparam int COPY_CYCLES  = 2 * PHOTO_PIXELS;    // read + write per pixel
    localparam int COPY_W       = $clog2(COPY_CYCLES);
    localparam int SEG_CYCLES   = GLYPH_W + 2;         // rom addr, load, 13 writes
    localparam int SEG_W        = $clog2(SEG_CYCLES);
    localparam int ROW_W        = $clog2(GLYPH_H);
    localparam int COL_W        = $clog2(N_GLYPH_COLS);
    localparam int BIT_W        = $clog2(GLYPH_W);

    // overlay colours
    localparam logic [PIX_W-1:0] PIX_ON  = 24'hffffff;
    localparam logic [PIX_W-1:0] PIX_OFF = 24'h000000;

    // time as stored in header word 0
    typedef struct packed {
        logic [7:0] hour;
        logic [7:0] minute;
        logic [7:0] second;
    } hms_t;

    // decimal digits for the overlay
    typedef struct packed {
        logic [3:0] h1;
        logic [3:0] h0;
        logic [3:0] m1;
        logic [3:0] m0;
        logic [3:0] s1;
        logic [3:0] s0;
    } digits_t;

    // controller strobes and selects into the datapath
    typedef struct packed {
        logic [HDR_WORDS-1:0] hdr_load;     // one-hot, per header word
        logic                 tick;         // last cycle of frame
        logic                 glyph_load;
        logic [BIT_W-1:0]     bit_idx;      // glyph column, 12 is leftmost
        logic                 overlay_sel;
    } ctrl_t;

endpackage

`default_nettype wire

//--- src/album_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module album_ctrl
    import album_pkg::*;
(
    input  wire               clk,
    input  wire               reset,
    input  wire [IM_AW-1:0]   fb_addr,
    input  wire [IM_AW-1:0]   photo_addr,
    input  wire digits_t      digits,
    output ctrl_t             ctrl,
    output logic [IM_AW-1:0]  im_a,
    output logic              im_wen_n,    // active low
    output logic [CR_AW-1:0]  cr_a
);

    typedef enum logic [1:0] {
        SETUP,
        COPY,
        OVERLAY,
        HOLD
    } state_t;

    // -------------------------------------------------------------------------
    // state and counters
    // -------------------------------------------------------------------------
    state_t             state;
    logic [FRAME_W-1:0] frame_cnt;   // cycle within frame, runs after setup
    logic [COPY_W-1:0]  pix_cnt;     // header step in setup, copy step in copy
    logic [ROW_W-1:0]   row;         // glyph row in overlay
    logic [COL_W-1:0]   col;         // glyph position in window
    logic [SEG_W-1:0]   seg;         // cycle within one glyph row segment

    logic               frame_end;
    logic               setup_end;
    logic               copy_end;
    logic               seg_end;
    logic               col_last;
    logic               ovl_end;

    logic [IM_AW-1:0]   pix_ofs;     // pixel offset during copy
    logic [IM_AW-1:0]   ovl_ofs;     // write offset in frame buffer during overlay
    logic [3:0]         glyph;       // rom glyph number for current column
    logic [CR_AW-1:0]   glyph_base;

    assign frame_end = (frame_cnt == FRAME_W'(FRAME_CYCLES - 1));
    assign setup_end = (pix_cnt == COPY_W'(SETUP_CYCLES - 1));
    assign copy_end  = (pix_cnt == COPY_W'(COPY_CYCLES - 1));
    assign seg_end   = (seg == SEG_W'(SEG_CYCLES - 1));
    assign col_last  = (col == COL_W'(N_GLYPH_COLS - 1));
    assign ovl_end   = seg_end && col_last && (row == ROW_W'(GLYPH_H - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= SETUP;
            frame_cnt <= '0;
            pix_cnt   <= '0;
            row       <= '0;
            col       <= '0;
            seg       <= '0;
        end else begin
            // frame timer starts with the first copy cycle
            if (state != SETUP) begin
                frame_cnt <= frame_end ? '0 : frame_cnt + 1'b1;
            end

            case (state)
                SETUP: begin
                    if (setup_end) begin
                        state   <= COPY;
                        pix_cnt <= '0;
                    end else begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end
                end
                COPY: begin
                    pix_cnt <= copy_end ? '0 : pix_cnt + 1'b1;
                    if (copy_end) begin
                        state <= OVERLAY;
                        row   <= '0;
                        col   <= '0;
                        seg   <= '0;
                    end
                end
                OVERLAY: begin
                    if (seg_end) begin
                        seg <= '0;
                        // row-major: all columns of a row, then next row
                        if (col_last) begin
                            col <= '0;
                            row <= row + 1'b1;
                        end else begin
                            col <= col + 1'b1;
                        end
                        if (ovl_end) begin
                            state <= HOLD;
                        end
                    end else begin
                        seg <= seg + 1'b1;
                    end
                end
                HOLD: begin
                    if (frame_end) begin
                        state   <= COPY;    // next photo, next second
                        pix_cnt <= '0;
                    end
                end
                default: state <= SETUP;
            endcase
        end
    end

    // -------------------------------------------------------------------------
    // address generation
    // -------------------------------------------------------------------------
    assign pix_ofs = IM_AW'(pix_cnt[COPY_W-1:1]);    // bit 0 is read/write phase

    assign ovl_ofs = CR_OFFSET
                   + IM_AW'(row) * IM_AW'(PHOTO_SIDE)
                   + IM_AW'(col) * IM_AW'(GLYPH_W)
                   + IM_AW'(seg - SEG_W'(2));           // first write at seg 2

    // columns 2 and 5 hold the colons
    always_comb begin
        case (col)
            3'd0:    glyph = digits.h1;
            3'd1:    glyph = digits.h0;
            3'd3:    glyph = digits.m1;
            3'd4:    glyph = digits.m0;
            3'd6:    glyph = digits.s1;
            3'd7:    glyph = digits.s0;
            default: glyph = 4'(COLON_GLYPH);
        endcase
    end

    assign glyph_base = CR_AW'(glyph) * CR_AW'(GLYPH_H);

    // -------------------------------------------------------------------------
    // memory strobes and datapath controls
    // -------------------------------------------------------------------------
    always_comb begin
        ctrl     = '0;
        im_a     = '0;
        im_wen_n = 1'b1;
        cr_a     = '0;
        case (state)
            SETUP: begin
                im_a = IM_AW'(pix_cnt);
                // word k shows on im_q the cycle after it is addressed
                if (pix_cnt != '0) begin
                    ctrl.hdr_load = HDR_WORDS'(1) << (pix_cnt - 1'b1);
                end
            end
            COPY: begin
                if (pix_cnt[0]) begin
                    im_a     = fb_addr + pix_ofs;  // im_q carries last read
                    im_wen_n = 1'b0;
                end else begin
                    im_a = photo_addr + pix_ofs;
                end
            end
            OVERLAY: begin
                cr_a            = glyph_base + CR_AW'(row);
                ctrl.glyph_load = (seg == SEG_W'(1));  // rom word valid now
                if (seg > SEG_W'(1)) begin
                    im_a             = fb_addr + ovl_ofs;
                    im_wen_n         = 1'b0;
                    ctrl.overlay_sel = 1'b1;
                    ctrl.bit_idx     = BIT_W'(SEG_CYCLES - 1) - BIT_W'(seg);
                end
            end
            HOLD: begin
                ctrl.tick = frame_end;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/album_regs.sv
`timescale 1ns/1ps
`default_nettype none

module album_regs
    import album_pkg::*;
(
    input  wire               clk,
    input  wire               reset,
    input  wire ctrl_t        ctrl,
    input  wire [PIX_W-1:0]   im_q,
    output logic [IM_AW-1:0]  fb_addr,
    output logic [IM_AW-1:0]  photo_addr,
    output hms_t              time_init
);

    logic [SLOT_W-1:0] photo_num;                  // index of last photo
    logic [IM_AW-1:0]  slot_addr [N_PHOTO_SLOTS];  // photo start table
    logic [SLOT_W-1:0] photo_idx;

    // -------------------------------------------------------------------------
    // header words 1 to 6, straight off the read port
    // -------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (ctrl.hdr_load[1]) begin
            fb_addr <= im_q[IM_AW-1:0];
        end
        if (ctrl.hdr_load[2]) begin
            photo_num <= im_q[SLOT_W-1:0];
        end
        for (int k = 0; k < N_PHOTO_SLOTS; k++) begin
            if (ctrl.hdr_load[3+k]) begin
                slot_addr[k] <= im_q[IM_AW-1:0];
            end
        end
    end

    // photo index, steps at end of frame
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            photo_idx <= '0;
        end else if (ctrl.tick) begin
            photo_idx <= (photo_idx == photo_num) ? '0 : photo_idx + 1'b1;
        end
    end

    assign photo_addr = slot_addr[photo_idx];
    assign time_init  = hms_t'(im_q);    // word 0, loaded by time_keeper

endmodule

`default_nettype wire

//--- src/time_keeper.sv
`timescale 1ns/1ps
`default_nettype none

module time_keeper
    import album_pkg::*;
(
    input  wire          clk,
    input  wire          reset,
    input  wire ctrl_t   ctrl,
    input  wire hms_t    time_init,
    output digits_t      digits
);

    hms_t cur_time;

    // -------------------------------------------------------------------------
    // time register
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cur_time <= '0;
        end else if (ctrl.hdr_load[0]) begin
            cur_time <= time_init;              // header word 0
        end else if (ctrl.tick) begin
            // one second per frame, carry into minutes and hours
            if (cur_time.second == 8'd59) begin
                cur_time.second <= 8'd0;
                if (cur_time.minute == 8'd59) begin
                    cur_time.minute <= 8'd0;
                    if (cur_time.hour == 8'd23) begin
                        cur_time.hour <= 8'd0;  // midnight
                    end else begin
                        cur_time.hour <= cur_time.hour + 8'd1;
                    end
                end else begin
                    cur_time.minute <= cur_time.minute + 8'd1;
                end
            end else begin
                cur_time.second <= cur_time.second + 8'd1;
            end
        end
    end

    // -------------------------------------------------------------------------
    // tens and units split
    // -------------------------------------------------------------------------
    assign digits.h1 = 4'(cur_time.hour / 8'd10);
    assign digits.h0 = 4'(cur_time.hour % 8'd10);
    assign digits.m1 = 4'(cur_time.minute / 8'd10);
    assign digits.m0 = 4'(cur_time.minute % 8'd10);
    assign digits.s1 = 4'(cur_time.second / 8'd10);
    assign digits.s0 = 4'(cur_time.second % 8'd10);

endmodule

`default_nettype wire

//--- src/pixel_path.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_path
    import album_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire ctrl_t          ctrl,
    input  wire [PIX_W-1:0]     im_q,
    input  wire [GLYPH_W-1:0]   cr_q,
    output logic [PIX_W-1:0]    im_d
);

    // -------------------------------------------------------------------------
    // glyph row register
    // -------------------------------------------------------------------------
    logic [GLYPH_W-1:0] glyph_row;    // bit 12 is leftmost pixel
    logic               pix_bit;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            glyph_row <= '0;
        end else if (ctrl.glyph_load) begin
            glyph_row <= cr_q;        // rom word one cycle after cr_a
        end
    end

    assign pix_bit = glyph_row[ctrl.bit_idx];

    // -------------------------------------------------------------------------
    // write data mux
    // -------------------------------------------------------------------------
    always_comb begin
        if (ctrl.overlay_sel) begin
            // clock overlay, white on black
            im_d = pix_bit ? PIX_ON : PIX_OFF;
        end else begin
            im_d = im_q;              // photo copy, same-cycle read data
        end
    end

endmodule

`default_nettype wire

//--- src/album_top.sv
`timescale 1ns/1ps
`default_nettype none

module album_top
    import album_pkg::*;
(
    input  wire                clk,
    input  wire                reset,

    // image memory
    output logic [IM_AW-1:0]   im_a,
    output logic               im_wen_n,
    output logic [PIX_W-1:0]   im_d,
    input  wire  [PIX_W-1:0]   im_q,

    // character rom
    output logic [CR_AW-1:0]   cr_a,
    input  wire  [GLYPH_W-1:0] cr_q
);

    // -------------------------------------------------------------------------
    // internal wiring
    // -------------------------------------------------------------------------
    ctrl_t              ctrl;         // controller to all datapath blocks
    logic [IM_AW-1:0]   fb_addr;
    logic [IM_AW-1:0]   photo_addr;   // start of current photo
    hms_t               time_init;    // header word 0
    digits_t            digits;

    album_ctrl album_ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .fb_addr    (fb_addr),
        .photo_addr (photo_addr),
        .digits     (digits),
        .ctrl       (ctrl),
        .im_a       (im_a),
        .im_wen_n   (im_wen_n),
        .cr_a       (cr_a)
    );

    album_regs album_regs_i (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .im_q       (im_q),
        .fb_addr    (fb_addr),
        .photo_addr (photo_addr),
        .time_init  (time_init)
    );

    time_keeper time_keeper_i (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .time_init  (time_init),
        .digits     (digits)
    );

    // write data, copy pass-through or glyph colour
    pixel_path pixel_path_i (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .im_q       (im_q),
        .cr_q       (cr_q),
        .im_d       (im_d)
    );

endmodule

`default_nettype wire

//--- verif/album_tb.sv
`timescale 1ns/1ps
`default_nettype none

module album_tb
    import album_pkg::*;
();

    logic               clk;
    logic               reset;
    logic [IM_AW-1:0]   im_a;
    logic               im_wen_n;
    logic [PIX_W-1:0]   im_d;
    logic [PIX_W-1:0]   im_q;
    logic [CR_AW-1:0]   cr_a;
    logic [GLYPH_W-1:0] cr_q;

    // memory models and reference copies
    logic [PIX_W-1:0]   im_mem [logic [IM_AW-1:0]];
    logic [PIX_W-1:0]   photo_ref [N_PHOTO_SLOTS][PHOTO_PIXELS];
    logic [GLYPH_W-1:0] rom [(COLON_GLYPH + 1) * GLYPH_H];   // 11 glyphs
    logic [IM_AW-1:0]   smp_a = '0;          // outputs latched mid-cycle
    logic               smp_wen_n = 1'b1;
    logic [PIX_W-1:0]   smp_d = '0;
    logic [CR_AW-1:0]   smp_cr_a = '0;

    // header and per-frame expectations from the stimulus file
    hms_t               start_time;
    logic [IM_AW-1:0]   fb_addr;
    logic [IM_AW-1:0]   photo_num;
    logic [IM_AW-1:0]   slot_addr [N_PHOTO_SLOTS];
    hms_t               exp_time [$];
    int                 exp_slot [$];

    integer             seed = 32'h1cd7;
    longint             cyc = 0;             // negedges seen by the checker
    logic [IM_AW-1:0]   prev_a;              // im_a one cycle back

    album_top album_top_i (
        .clk      (clk),
        .reset    (reset),
        .im_a     (im_a),
        .im_wen_n (im_wen_n),
        .im_d     (im_d),
        .im_q     (im_q),
        .cr_a     (cr_a),
        .cr_q     (cr_q)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;               // 4 ns period
    end

    // ------------------------------------------------------------------------
    // image memory and char rom, one cycle read latency
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        smp_a     = im_a;
        smp_wen_n = im_wen_n;
        smp_d     = im_d;
        smp_cr_a  = cr_a;
    end

    initial begin
        im_q = '0;
        cr_q = '0;
        forever begin
            @(posedge clk);
            #1;
            im_q = mem_read(smp_a);          // read before write, old data
            if (!smp_wen_n) begin
                im_mem[smp_a] = smp_d;
            end
            cr_q = rom[smp_cr_a];
        end
    end

    function automatic logic [PIX_W-1:0] mem_read(input logic [IM_AW-1:0] a);
        if (im_mem.exists(a)) begin
            return im_mem[a];
        end else begin
            return '0;                       // never written
        end
    endfunction

    // glyph number shown in window column col
    function automatic int col_glyph(input int col, input hms_t t);
        case (col)
            0:       return t.hour / 10;
            1:       return t.hour % 10;
            3:       return t.minute / 10;
            4:       return t.minute % 10;
            6:       return t.second / 10;
            7:       return t.second % 10;
            default: return COLON_GLYPH;     // columns 2 and 5
        endcase
    endfunction

    function automatic logic [PIX_W-1:0] glyph_pixel(input int g, input int row, input int b);
        logic [GLYPH_W-1:0] w;
        w = rom[g * GLYPH_H + row];
        if (w[b]) begin
            return PIX_ON;
        end else begin
            return PIX_OFF;
        end
    endfunction

    // ------------------------------------------------------------------------
    // failure reporting and checks
    // ------------------------------------------------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        report_failure($sformatf("ERR %s expected %0h actual %0h", name, exp, act));
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else report_mismatch(name, exp, act);
    endtask

    task automatic next_cycle();
        prev_a = im_a;
        @(negedge clk);                      // outputs settled since posedge+1
        cyc++;
    endtask

    task automatic load_stimulus();
        int    fd;
        int    n;
        int    fno;
        int    hh;
        int    mm;
        int    ss;
        int    slot;
        string line;
        string kind;
        hms_t  t;
        fd = $fopen("verif/album_stimulus.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open verif/album_stimulus.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;                    // blank or comment
            end
            n = $sscanf(line, "%s", kind);
            if (kind == "hdr") begin
                n = $sscanf(line, "hdr %d %d %d %h %h %h %h %h %h", hh, mm, ss, fb_addr,
                            photo_num, slot_addr[0], slot_addr[1], slot_addr[2],
                            slot_addr[3]);
                if (n != 9) begin
                    report_failure("malformed hdr line in stimulus file");
                end
                start_time.hour   = 8'(hh);
                start_time.minute = 8'(mm);
                start_time.second = 8'(ss);
            end else if (kind == "frame") begin
                n = $sscanf(line, "frame %d %d %d %d %d", fno, hh, mm, ss, slot);
                if (n != 5 || fno != exp_time.size()) begin
                    report_failure("malformed or out of order frame line in stimulus file");
                end
                t.hour   = 8'(hh);
                t.minute = 8'(mm);
                t.second = 8'(ss);
                exp_time.push_back(t);
                exp_slot.push_back(slot);
            end
        end
        $fclose(fd);
        if (exp_time.size() == 0) begin
            report_failure("stimulus file holds no frame lines");
        end
    endtask

    task automatic fill_memories();
        logic [31:0] r;
        for (int k = 0; k < N_PHOTO_SLOTS; k++) begin
            for (int i = 0; i < PHOTO_PIXELS; i++) begin
                r = $random(seed);
                photo_ref[k][i] = r[PIX_W-1:0];
                im_mem[slot_addr[k] + IM_AW'(i)] = r[PIX_W-1:0];
            end
        end
        for (int j = 0; j < (COLON_GLYPH + 1) * GLYPH_H; j++) begin
            r = $random(seed);
            rom[j] = r[GLYPH_W-1:0];
        end
        // header words 0 to 6
        im_mem[IM_AW'(0)] = start_time;
        im_mem[IM_AW'(1)] = PIX_W'(fb_addr);
        im_mem[IM_AW'(2)] = PIX_W'(photo_num);
        for (int k = 0; k < N_PHOTO_SLOTS; k++) begin
            im_mem[IM_AW'(3 + k)] = PIX_W'(slot_addr[k]);
        end
    endtask

    // header reads, then the first write on cycle 9 after reset
    task automatic check_setup();
        for (int k = 0; k < HDR_WORDS + 2; k++) begin
            next_cycle();
            check_value("setup_no_write", 1, im_wen_n);
            if (k < HDR_WORDS) begin
                check_value("setup_header_addr", k, im_a);
            end
        end
        next_cycle();
        check_value("first_write_latency", 0, im_wen_n);
    endtask

    task automatic wait_first_write();
        int n;
        n = 0;
        next_cycle();
        while (im_wen_n !== 1'b0) begin
            if (n >= FRAME_CYCLES) begin
                report_failure("timeout waiting for the first write of a frame");
            end
            next_cycle();
            n++;
        end
    endtask

    // entered on the write cycle of pixel 0
    task automatic check_copy(input int slot);
        logic [IM_AW-1:0] src;
        logic [IM_AW-1:0] dst;
        for (int i = 0; i < PHOTO_PIXELS; i++) begin
            src = slot_addr[slot] + IM_AW'(i);
            dst = fb_addr + IM_AW'(i);
            if (i > 0) begin
                next_cycle();                // read cycle
                check_value("copy_read_strobe", 1, im_wen_n);
                next_cycle();
            end
            check_value("copy_read_addr", src, prev_a);
            check_value("copy_write_strobe", 0, im_wen_n);
            check_value("copy_write_addr", dst, im_a);
            check_value("copy_write_data", photo_ref[slot][i], im_d);
        end
    endtask

    task automatic check_overlay(input hms_t t);
        int               g;
        logic [IM_AW-1:0] a;
        for (int row = 0; row < GLYPH_H; row++) begin
            for (int col = 0; col < N_GLYPH_COLS; col++) begin
                g = col_glyph(col, t);
                next_cycle();                // rom address cycle
                check_value("overlay_rom_addr", g * GLYPH_H + row, cr_a);
                check_value("overlay_rom_strobe", 1, im_wen_n);
                next_cycle();                // glyph row loads
                check_value("overlay_load_strobe", 1, im_wen_n);
                for (int x = 0; x < GLYPH_W; x++) begin
                    next_cycle();
                    a = fb_addr + CR_OFFSET + IM_AW'(row * PHOTO_SIDE + col * GLYPH_W + x);
                    check_value("overlay_write_strobe", 0, im_wen_n);
                    check_value("overlay_write_addr", a, im_a);
                    check_value("overlay_write_data", glyph_pixel(g, row, GLYPH_W - 1 - x),
                                im_d);
                end
            end
        end
        next_cycle();
        check_value("hold_no_write", 1, im_wen_n);
    endtask

    // whole frame buffer after the overlay has landed
    task automatic check_frame_buffer(input int slot, input hms_t t);
        int               y0;
        int               x0;
        int               wx;
        logic [PIX_W-1:0] got;
        y0 = int'(CR_OFFSET) / PHOTO_SIDE;
        x0 = int'(CR_OFFSET) % PHOTO_SIDE;
        for (int y = 0; y < PHOTO_SIDE; y++) begin
            for (int x = 0; x < PHOTO_SIDE; x++) begin
                got = mem_read(fb_addr + IM_AW'(y * PHOTO_SIDE + x));
                wx  = x - x0;
                if (y >= y0 && y < y0 + GLYPH_H && wx >= 0 && wx < N_GLYPH_COLS * GLYPH_W) begin
                    check_value("fb_overlay_pixel", glyph_pixel(col_glyph(wx / GLYPH_W, t),
                                y - y0, GLYPH_W - 1 - wx % GLYPH_W), got);
                end else begin
                    check_value("fb_photo_pixel", photo_ref[slot][y * PHOTO_SIDE + x], got);
                end
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        longint last_start;
        reset = 1'b1;
        load_stimulus();
        fill_memories();
        repeat (4) begin
            @(posedge clk);
            #1;
            check_value("reset_no_write", 1, im_wen_n);
        end
        reset = 1'b0;                        // released 1 ns after the 4th edge
        check_setup();
        last_start = cyc;
        for (int f = 0; f < exp_time.size(); f++) begin
            if (f > 0) begin
                wait_first_write();
                check_value("frame_length", FRAME_CYCLES, 32'(cyc - last_start));
                last_start = cyc;
            end
            check_copy(exp_slot[f]);
            check_overlay(exp_time[f]);
            check_frame_buffer(exp_slot[f], exp_time[f]);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- album.f
src/album_pkg.sv
src/album_ctrl.sv
src/album_regs.sv
src/time_keeper.sv
src/pixel_path.sv
src/album_top.sv
verif/album_tb.sv

//--- Makefile
# Verilator build and run for the photo album controller

TOP       ?= album_tb
FILELIST  ?= album.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SOURCES   := $(wildcard src/*.sv verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the testbench reads verif/album_stimulus.txt, so run from the project root
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG) || ! grep -q "Simulation passed" $(LOG); then \
		echo "result: FAIL"; \
		exit 1; \
	else \
		echo "result: PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/album_stimulus.txt
# hdr: start hh mm ss (decimal), then fb_addr photo_num slot0 slot1 slot2 slot3 (hex)
# frame: frame number, expected hh mm ss on screen (decimal), expected photo slot

hdr 23 59 59 80000 1 10000 20000 30000 40000

# first frame shows the start time and slot 0
frame 0 23 59 59 0

# midnight rollover, photo index steps to 1
frame 1 0 0 0 1

# photo_num is 1 so the index wraps back to slot 0
frame 2 0 0 1 0
